// File: rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte offset inside a 32-byte line
`define CACHE_OFFSET_BITS 5

// 16 sets
`define CACHE_INDEX_BITS 4

// whatever is left of the 32-bit address
`define CACHE_TAG_BITS (32 - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS)

// one line, 32 bytes
`define CACHE_LINE_BITS 256

// byte enables per line
`define CACHE_MASK_BITS (`CACHE_LINE_BITS / 8)

// set count follows the index width
`define CACHE_SETS (1 << `CACHE_INDEX_BITS)

// tied to the 3-bit plru tree
`define CACHE_WAYS 4

`endif

// File: rtl/cache_pkg.sv
package cache_pkg;

    // main fsm states
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        COMPARE   = 2'b01,
        WRITEBACK = 2'b10,
        ALLOCATE  = 2'b11
    } cache_state_e;

    // valid / dirty bit operation
    typedef enum logic [1:0] {
        META_HOLD  = 2'b00,
        META_SET   = 2'b01,
        META_CLEAR = 2'b10
    } meta_op_e;

    // which way a select refers to
    typedef enum logic {
        WAY_HIT    = 1'b0,
        WAY_VICTIM = 1'b1
    } way_src_e;

    // data array write source
    typedef enum logic {
        DIN_CPU = 1'b0,
        DIN_MEM = 1'b1
    } din_src_e;

endpackage

// File: rtl/cache_way_meta.sv
`include "cache_defs.svh"

module cache_way_meta (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [`CACHE_INDEX_BITS-1:0] set_i,
    input  logic [`CACHE_TAG_BITS-1:0]   tag_i,
    input  logic [`CACHE_WAYS-1:0]       tag_we_i,
    input  cache_pkg::meta_op_e          dirty_op_i,
    input  cache_pkg::meta_op_e          valid_op_i,
    input  logic [1:0]                   way_i,
    output logic [`CACHE_WAYS-1:0]       hit_map_o,
    output logic [`CACHE_TAG_BITS-1:0]   tag_o,
    output logic                         dirty_o
);

    // tag storage, set major
    logic [`CACHE_TAG_BITS-1:0] tag_q [`CACHE_SETS][`CACHE_WAYS];
    // one valid and one dirty bit per way
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];

    // tag write, only the way picked for allocation
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (tag_we_i[w]) begin
                tag_q[set_i][w] <= tag_i;
            end
        end
    end

    // valid and dirty bits, cleared by reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            case (valid_op_i)
                cache_pkg::META_SET:   valid_q[set_i][way_i] <= 1'b1;
                cache_pkg::META_CLEAR: valid_q[set_i][way_i] <= 1'b0;
                default: ;
            endcase
            case (dirty_op_i)
                cache_pkg::META_SET:   dirty_q[set_i][way_i] <= 1'b1;
                cache_pkg::META_CLEAR: dirty_q[set_i][way_i] <= 1'b0;
                default: ;
            endcase
        end
    end

    // parallel compare, an invalid way never hits
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_map_o[w] = valid_q[set_i][w] && (tag_q[set_i][w] == tag_i);
        end
    end

    // tag and dirty of the selected way
    // victim tag feeds the writeback address
    assign tag_o   = tag_q[set_i][way_i];
    assign dirty_o = dirty_q[set_i][way_i];

    // allocation only happens on a miss, so a tag never lives in two ways
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(hit_map_o))
        else $error("hit map has more than one way set");

endmodule

// File: rtl/cache_plru.sv
`include "cache_defs.svh"

module cache_plru (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [`CACHE_INDEX_BITS-1:0] set_i,
    input  logic                         update_i,
    input  logic [1:0]                   way_used_i,
    output logic [1:0]                   victim_o,
    output logic [`CACHE_WAYS-1:0]       victim_map_o
);

    // tree per set
    // bit 0 root: 0 points left (ways 0/1), 1 points right (ways 2/3)
    // bit 1 left pair, bit 2 right pair: 0 points at the lower way
    logic [2:0] tree_q [`CACHE_SETS];
    logic [2:0] tree;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update_i) begin
            // root turns to the other half
            tree_q[set_i][0] <= ~way_used_i[1];
            // pair bit turns to the sibling
            if (way_used_i[1]) begin
                tree_q[set_i][2] <= ~way_used_i[0];
            end else begin
                tree_q[set_i][1] <= ~way_used_i[0];
            end
        end
    end

    assign tree = tree_q[set_i];

    // follow the tree bits down to a leaf
    assign victim_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    // one-hot form for write enables
    always_comb begin
        victim_map_o = '0;
        victim_map_o[victim_o] = 1'b1;
    end

endmodule

// File: rtl/cache_datapath.sv
`include "cache_defs.svh"

module cache_datapath (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [31:0]                  address_i,
    input  logic [`CACHE_LINE_BITS-1:0]  cpu_wdata_i,
    input  logic [`CACHE_MASK_BITS-1:0]  cpu_wmask_i,
    input  logic [`CACHE_LINE_BITS-1:0]  mem_rdata_i,
    input  cache_pkg::way_src_e          data_we_src_i,
    input  logic                         data_we_i,
    input  logic                         use_mask_i,
    input  cache_pkg::din_src_e          din_src_i,
    input  cache_pkg::way_src_e          dout_src_i,
    input  logic                         tag_we_i,
    input  cache_pkg::meta_op_e          dirty_op_i,
    input  cache_pkg::meta_op_e          valid_op_i,
    input  logic                         plru_update_i,
    input  logic                         victim_addr_sel_i,
    output logic [`CACHE_LINE_BITS-1:0]  rdata_o,
    output logic [`CACHE_LINE_BITS-1:0]  mem_wdata_o,
    output logic [31:0]                  mem_address_o,
    output logic                         hit_o,
    output logic                         victim_dirty_o
);

    // data storage, way major
    logic [`CACHE_LINE_BITS-1:0] data_q [`CACHE_WAYS][`CACHE_SETS];

    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic [`CACHE_INDEX_BITS-1:0] set;
    logic [`CACHE_WAYS-1:0]       hit_map;
    logic [`CACHE_WAYS-1:0]       victim_map;
    logic [`CACHE_WAYS-1:0]       we_map;
    logic [1:0]                   hit_way;
    logic [1:0]                   victim_way;
    logic [1:0]                   meta_way;
    logic [1:0]                   dout_way;
    logic [`CACHE_TAG_BITS-1:0]   victim_tag;
    logic [`CACHE_MASK_BITS-1:0]  wmask;
    logic [`CACHE_LINE_BITS-1:0]  din;

    // address split
    assign tag = address_i[31 -: `CACHE_TAG_BITS];
    assign set = address_i[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    cache_way_meta u_way_meta (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .set_i      (set),
        .tag_i      (tag),
        .tag_we_i   (tag_we_i ? victim_map : '0),
        .dirty_op_i (dirty_op_i),
        .valid_op_i (valid_op_i),
        .way_i      (meta_way),
        .hit_map_o  (hit_map),
        .tag_o      (victim_tag),
        .dirty_o    (victim_dirty_o)
    );

    // touched way only counts on a hit
    cache_plru u_plru (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .set_i        (set),
        .update_i     (plru_update_i),
        .way_used_i   (hit_way),
        .victim_o     (victim_way),
        .victim_map_o (victim_map)
    );

    assign hit_o = |hit_map;

    // encode the hit map, only meaningful when hit_o is high
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hit_map[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    // write way also targets the valid/dirty ops
    // on a miss control points it at the victim so dirty reads back the victim
    assign meta_way = (data_we_src_i == cache_pkg::WAY_HIT) ? hit_way : victim_way;
    assign we_map   = !data_we_i ? '0 :
                      (data_we_src_i == cache_pkg::WAY_HIT) ? hit_map : victim_map;

    // full line on a fill, byte enables on a write hit
    assign wmask = use_mask_i ? cpu_wmask_i : '1;
    assign din   = (din_src_i == cache_pkg::DIN_MEM) ? mem_rdata_i : cpu_wdata_i;

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            for (int b = 0; b < `CACHE_MASK_BITS; b++) begin
                if (we_map[w] && wmask[b]) begin
                    data_q[w][set][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    // hit way for reads, victim way during writeback
    assign dout_way    = (dout_src_i == cache_pkg::WAY_HIT) ? hit_way : victim_way;
    assign rdata_o     = data_q[dout_way][set];
    assign mem_wdata_o = data_q[dout_way][set];

    // fill uses the request line, writeback rebuilds the victim line
    assign mem_address_o = victim_addr_sel_i ?
        {victim_tag, set, {`CACHE_OFFSET_BITS{1'b0}}} :
        {address_i[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}};

endmodule

// File: rtl/cache_control.sv
module cache_control (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                cpu_read_i,
    input  logic                cpu_write_i,
    input  logic                hit_i,
    input  logic                victim_dirty_i,
    input  logic                mem_resp_i,
    output cache_pkg::way_src_e data_we_src_o,
    output logic                data_we_o,
    output logic                use_mask_o,
    output cache_pkg::din_src_e din_src_o,
    output cache_pkg::way_src_e dout_src_o,
    output logic                tag_we_o,
    output cache_pkg::meta_op_e dirty_op_o,
    output cache_pkg::meta_op_e valid_op_o,
    output logic                plru_update_o,
    output logic                victim_addr_sel_o,
    output logic                cpu_resp_o,
    output logic                mem_read_o,
    output logic                mem_write_o
);

    cache_pkg::cache_state_e state_q;
    cache_pkg::cache_state_e state_d;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= cache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        // quiet defaults, arrays only read
        state_d           = state_q;
        data_we_src_o     = cache_pkg::WAY_HIT;
        data_we_o         = 1'b0;
        use_mask_o        = 1'b0;
        din_src_o         = cache_pkg::DIN_CPU;
        dout_src_o        = cache_pkg::WAY_HIT;
        tag_we_o          = 1'b0;
        dirty_op_o        = cache_pkg::META_HOLD;
        valid_op_o        = cache_pkg::META_HOLD;
        plru_update_o     = 1'b0;
        victim_addr_sel_o = 1'b0;
        cpu_resp_o        = 1'b0;
        mem_read_o        = 1'b0;
        mem_write_o       = 1'b0;

        case (state_q)
            cache_pkg::IDLE: begin
                if (cpu_read_i || cpu_write_i) begin
                    state_d = cache_pkg::COMPARE;
                end
            end
            cache_pkg::COMPARE: begin
                if (hit_i) begin
                    // respond now, write hit merges bytes and marks dirty
                    cpu_resp_o    = 1'b1;
                    plru_update_o = 1'b1;
                    if (cpu_write_i) begin
                        data_we_o  = 1'b1;
                        use_mask_o = 1'b1;
                        dirty_op_o = cache_pkg::META_SET;
                    end
                    state_d = cache_pkg::IDLE;
                end else begin
                    // look at the victim to decide on writeback
                    data_we_src_o = cache_pkg::WAY_VICTIM;
                    state_d = victim_dirty_i ? cache_pkg::WRITEBACK : cache_pkg::ALLOCATE;
                end
            end
            cache_pkg::WRITEBACK: begin
                // victim line out at its own address
                data_we_src_o     = cache_pkg::WAY_VICTIM;
                dout_src_o        = cache_pkg::WAY_VICTIM;
                victim_addr_sel_o = 1'b1;
                mem_write_o       = 1'b1;
                if (mem_resp_i) begin
                    state_d = cache_pkg::ALLOCATE;
                end
            end
            cache_pkg::ALLOCATE: begin
                data_we_src_o = cache_pkg::WAY_VICTIM;
                mem_read_o    = 1'b1;
                // fill lands with the response pulse
                if (mem_resp_i) begin
                    data_we_o  = 1'b1;
                    din_src_o  = cache_pkg::DIN_MEM;
                    tag_we_o   = 1'b1;
                    valid_op_o = cache_pkg::META_SET;
                    dirty_op_o = cache_pkg::META_CLEAR;
                    state_d    = cache_pkg::COMPARE;
                end
            end
            default: state_d = cache_pkg::IDLE;
        endcase
    end

    // one memory transaction at a time
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem_read_o && mem_write_o))
        else $error("memory read and write requested together");

    // response is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cpu_resp_o |=> !cpu_resp_o)
        else $error("cpu response held longer than one cycle");

endmodule

// File: rtl/cache_top.sv
`include "cache_defs.svh"

module cache_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    // cpu side
    input  logic                        cpu_read_i,
    input  logic                        cpu_write_i,
    input  logic [31:0]                 cpu_address_i,
    input  logic [`CACHE_LINE_BITS-1:0] cpu_wdata_i,
    input  logic [`CACHE_MASK_BITS-1:0] cpu_wmask_i,
    output logic [`CACHE_LINE_BITS-1:0] cpu_rdata_o,
    output logic                        cpu_resp_o,
    // memory side
    output logic                        mem_read_o,
    output logic                        mem_write_o,
    output logic [31:0]                 mem_address_o,
    output logic [`CACHE_LINE_BITS-1:0] mem_wdata_o,
    input  logic [`CACHE_LINE_BITS-1:0] mem_rdata_i,
    input  logic                        mem_resp_i
);

    // control to datapath
    cache_pkg::way_src_e data_we_src;
    logic                data_we;
    logic                use_mask;
    cache_pkg::din_src_e din_src;
    cache_pkg::way_src_e dout_src;
    logic                tag_we;
    cache_pkg::meta_op_e dirty_op;
    cache_pkg::meta_op_e valid_op;
    logic                plru_update;
    logic                victim_addr_sel;
    // datapath status back
    logic                hit;
    logic                victim_dirty;

    cache_control u_control (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .cpu_read_i        (cpu_read_i),
        .cpu_write_i       (cpu_write_i),
        .hit_i             (hit),
        .victim_dirty_i    (victim_dirty),
        .mem_resp_i        (mem_resp_i),
        .data_we_src_o     (data_we_src),
        .data_we_o         (data_we),
        .use_mask_o        (use_mask),
        .din_src_o         (din_src),
        .dout_src_o        (dout_src),
        .tag_we_o          (tag_we),
        .dirty_op_o        (dirty_op),
        .valid_op_o        (valid_op),
        .plru_update_o     (plru_update),
        .victim_addr_sel_o (victim_addr_sel),
        .cpu_resp_o        (cpu_resp_o),
        .mem_read_o        (mem_read_o),
        .mem_write_o       (mem_write_o)
    );

    cache_datapath u_datapath (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .address_i         (cpu_address_i),
        .cpu_wdata_i       (cpu_wdata_i),
        .cpu_wmask_i       (cpu_wmask_i),
        .mem_rdata_i       (mem_rdata_i),
        .data_we_src_i     (data_we_src),
        .data_we_i         (data_we),
        .use_mask_i        (use_mask),
        .din_src_i         (din_src),
        .dout_src_i        (dout_src),
        .tag_we_i          (tag_we),
        .dirty_op_i        (dirty_op),
        .valid_op_i        (valid_op),
        .plru_update_i     (plru_update),
        .victim_addr_sel_i (victim_addr_sel),
        .rdata_o           (cpu_rdata_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_address_o     (mem_address_o),
        .hit_o             (hit),
        .victim_dirty_o    (victim_dirty)
    );

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk_o = ~clk_o;
        end
    end

    // low from time zero, released after three rising edges
    initial begin
        arst_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// File: tests/cache_checker.sv
`include "cache_defs.svh"

module cache_checker (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        cpu_read_i,
    input  logic                        cpu_write_i,
    input  logic [31:0]                 cpu_address_i,
    input  logic [`CACHE_LINE_BITS-1:0] cpu_wdata_i,
    input  logic [`CACHE_MASK_BITS-1:0] cpu_wmask_i,
    input  logic [`CACHE_LINE_BITS-1:0] cpu_rdata_i,
    input  logic                        cpu_resp_i,
    input  logic                        mem_read_i,
    input  logic                        mem_write_i,
    input  logic [31:0]                 mem_address_i,
    input  logic [`CACHE_LINE_BITS-1:0] mem_wdata_i,
    input  logic                        mem_resp_i,
    input  logic                        expect_hit_i,
    input  logic                        expect_fill_i,
    input  logic                        expect_wb_i,
    input  logic                        done_i,
    output int                          error_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // what the cpu should see, keyed by line address
    logic [`CACHE_LINE_BITS-1:0] shadow_q [logic [26:0]];
    int errors = 0;
    int errors_before = 0;
    int tests = 0;
    int reads = 0;
    int writebacks = 0;
    int req_edges = 0;
    bit fill_seen = 0;
    bit wb_seen = 0;
    bit summary_done = 0;

    assign error_count_o = errors;

    // untouched memory, every address bit feeds each word
    function automatic logic [`CACHE_LINE_BITS-1:0] initial_line(input logic [26:0] line);
        logic [`CACHE_LINE_BITS-1:0] data;
        logic [31:0] addr;
        for (int w = 0; w < 8; w++) begin
            addr = {line, 3'(w), 2'b00};
            data[32*w +: 32] = addr ^ {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
        end
        return data;
    endfunction

    function automatic logic [`CACHE_LINE_BITS-1:0] shadow_line(input logic [26:0] line);
        return shadow_q.exists(line) ? shadow_q[line] : initial_line(line);
    endfunction

    task automatic value_error(input string name, input logic [`CACHE_LINE_BITS-1:0] expected,
                               input logic [`CACHE_LINE_BITS-1:0] actual);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic plain_error(input string text);
        $display("error at %0t: %s", $time, text);
        errors++;
    endtask

    // one request answered, compare and report
    task automatic finish_test();
        logic [26:0] line;
        logic [`CACHE_LINE_BITS-1:0] merged;
        string kind;
        line = cpu_address_i[31:`CACHE_OFFSET_BITS];
        merged = shadow_line(line);
        tests++;
        if (cpu_read_i) begin
            kind = "read ";
            reads++;
            if (cpu_rdata_i !== merged) begin
                value_error("cpu_rdata_o", merged, cpu_rdata_i);
            end
        end else begin
            kind = "write";
            for (int b = 0; b < `CACHE_MASK_BITS; b++) begin
                if (cpu_wmask_i[b]) begin
                    merged[8*b +: 8] = cpu_wdata_i[8*b +: 8];
                end
            end
            shadow_q[line] = merged;
        end
        if (expect_hit_i && req_edges != 2) begin
            plain_error($sformatf("hit answered after %0d edges instead of 2", req_edges));
        end
        if (expect_hit_i && (fill_seen || wb_seen)) begin
            plain_error("a hit went out to memory");
        end
        if (expect_fill_i && !fill_seen) begin
            plain_error("miss finished without fetching a line");
        end
        if (expect_wb_i && !wb_seen) begin
            plain_error("eviction of a dirty set wrote nothing back");
        end
        $display("test %0d %s %h after %0d edges %s", tests, kind, cpu_address_i, req_edges,
                 (errors == errors_before) ? "ok" : "FAILED");
        errors_before = errors;
        req_edges = 0;
        fill_seen = 0;
        wb_seen = 0;
    endtask

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            // handshake outputs quiet under reset
            if (cpu_resp_i !== 1'b0) begin
                value_error("cpu_resp_o", '0, cpu_resp_i);
            end
            if (mem_read_i !== 1'b0 || mem_write_i !== 1'b0) begin
                value_error("mem_read_o/mem_write_o", '0, {mem_read_i, mem_write_i});
            end
        end else begin
            if (cpu_read_i || cpu_write_i) begin
                req_edges++;
            end
            fill_seen = fill_seen || mem_read_i;
            wb_seen = wb_seen || mem_write_i;
            // fill names the requested line, aligned
            if (mem_read_i && mem_resp_i &&
                mem_address_i !== {cpu_address_i[31:`CACHE_OFFSET_BITS], 5'b0}) begin
                value_error("mem_address_o", {cpu_address_i[31:`CACHE_OFFSET_BITS], 5'b0},
                            mem_address_i);
            end
            // a dirty line leaves with everything the cpu wrote into it
            if (mem_write_i && mem_resp_i) begin
                writebacks++;
                // victim sits in the requested set, line aligned
                if (mem_address_i[8:0] !== {cpu_address_i[8:5], 5'b0}) begin
                    value_error("mem_address_o",
                                {mem_address_i[31:9], cpu_address_i[8:5], 5'b0}, mem_address_i);
                end
                // only a line the cpu wrote can be dirty
                if (!shadow_q.exists(mem_address_i[31:`CACHE_OFFSET_BITS])) begin
                    plain_error("writeback of a line the cpu never wrote");
                end
                if (mem_wdata_i !== shadow_line(mem_address_i[31:`CACHE_OFFSET_BITS])) begin
                    value_error("mem_wdata_o", shadow_line(mem_address_i[31:`CACHE_OFFSET_BITS]),
                                mem_wdata_i);
                end
            end
            if (cpu_resp_i) begin
                finish_test();
            end
            if (done_i && !summary_done) begin
                summary_done = 1;
                $display("summary: %0d tests, %0d reads checked, %0d writebacks, %0d errors",
                         tests, reads, writebacks, errors);
            end
        end
    end

endmodule

// File: tests/cache_tb.sv
`include "cache_defs.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_ROWS = 24;
    // expected path per row: {writeback, fill, hit}
    localparam logic [2:0] EXPECT_ANY = 3'b000;
    localparam logic [2:0] EXPECT_HIT = 3'b001;
    localparam logic [2:0] EXPECT_FILL = 3'b010;
    localparam logic [2:0] EXPECT_EVICT = 3'b110;

    logic clk;
    logic arst_n;
    logic cpu_read;
    logic cpu_write;
    logic [31:0] cpu_address;
    logic [`CACHE_LINE_BITS-1:0] cpu_wdata;
    logic [`CACHE_MASK_BITS-1:0] cpu_wmask;
    logic [`CACHE_LINE_BITS-1:0] cpu_rdata;
    logic cpu_resp;
    logic mem_read;
    logic mem_write;
    logic [31:0] mem_address;
    logic [`CACHE_LINE_BITS-1:0] mem_wdata;
    logic [`CACHE_LINE_BITS-1:0] mem_rdata;
    logic mem_resp;
    logic [2:0] expect_bits;
    logic done;
    int error_count;
    integer seed = 44703;

    // stimulus table, one entry per row in each queue
    bit is_write_q [$];
    logic [31:0] addr_q [$];
    logic [`CACHE_LINE_BITS-1:0] data_q [$];
    logic [`CACHE_MASK_BITS-1:0] mask_q [$];
    logic [2:0] expect_q [$];

    // sparse memory behind the cache
    logic [`CACHE_LINE_BITS-1:0] mem_q [logic [26:0]];

    tb_clock_gen u_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    cache_top DUT (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .cpu_read_i    (cpu_read),
        .cpu_write_i   (cpu_write),
        .cpu_address_i (cpu_address),
        .cpu_wdata_i   (cpu_wdata),
        .cpu_wmask_i   (cpu_wmask),
        .cpu_rdata_o   (cpu_rdata),
        .cpu_resp_o    (cpu_resp),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .mem_address_o (mem_address),
        .mem_wdata_o   (mem_wdata),
        .mem_rdata_i   (mem_rdata),
        .mem_resp_i    (mem_resp)
    );

    cache_checker u_checker (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .cpu_read_i    (cpu_read),
        .cpu_write_i   (cpu_write),
        .cpu_address_i (cpu_address),
        .cpu_wdata_i   (cpu_wdata),
        .cpu_wmask_i   (cpu_wmask),
        .cpu_rdata_i   (cpu_rdata),
        .cpu_resp_i    (cpu_resp),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .mem_address_i (mem_address),
        .mem_wdata_i   (mem_wdata),
        .mem_resp_i    (mem_resp),
        .expect_hit_i  (expect_bits[0]),
        .expect_fill_i (expect_bits[1]),
        .expect_wb_i   (expect_bits[2]),
        .done_i        (done),
        .error_count_o (error_count)
    );

    // power-up contents, a function of the whole word address
    function automatic logic [`CACHE_LINE_BITS-1:0] memory_image(input logic [26:0] line);
        logic [`CACHE_LINE_BITS-1:0] data;
        logic [31:0] addr;
        for (int w = 0; w < 8; w++) begin
            addr = {line, 3'(w), 2'b00};
            data[32*w +: 32] = addr ^ {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
        end
        return data;
    endfunction

    function automatic logic [`CACHE_LINE_BITS-1:0] random_line();
        logic [`CACHE_LINE_BITS-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = $random(seed);
        end
        return line;
    endfunction

    task automatic add_row(input bit is_write, input logic [31:0] addr,
                           input logic [`CACHE_LINE_BITS-1:0] data,
                           input logic [`CACHE_MASK_BITS-1:0] mask, input logic [2:0] expect_b);
        is_write_q.push_back(is_write);
        addr_q.push_back(addr);
        data_q.push_back(data);
        mask_q.push_back(mask);
        expect_q.push_back(expect_b);
    endtask

    task automatic build_table();
        logic [3:0] set;
        logic [22:0] tag;
        // one line in set 2: miss, hits, partial write
        add_row(1'b0, 32'h0000_1044, '0, '0, EXPECT_FILL);
        add_row(1'b0, 32'h0000_1040, '0, '0, EXPECT_HIT);
        add_row(1'b1, 32'h0000_105C, {8{32'hA1B2_C3D4}}, 32'hF000_000F, EXPECT_HIT);
        add_row(1'b0, 32'h0000_1040, '0, '0, EXPECT_HIT);
        // three more dirty lines fill every way of set 2
        add_row(1'b1, 32'h0000_2040, random_line(), 32'hFFFF_FFFF, EXPECT_FILL);
        add_row(1'b1, 32'h0000_3040, random_line(), 32'h0F0F_0F0F, EXPECT_FILL);
        add_row(1'b1, 32'h0000_4040, random_line(), 32'h8000_0001, EXPECT_FILL);
        // fifth tag pushes a dirty line out
        add_row(1'b0, 32'h0000_5040, '0, '0, EXPECT_EVICT);
        for (int t = 1; t <= 4; t++) begin
            add_row(1'b0, t * 32'h1000 + 32'h40, '0, '0, EXPECT_ANY);
        end
        // random traffic, six tags over sets 3, 7 and 11
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            set = 4'(3 + 4 * ($unsigned($random(seed)) % 3));
            tag = 23'(32 + $unsigned($random(seed)) % 6);
            add_row(1'($random(seed)), {tag, set, 5'($random(seed))}, random_line(),
                    $random(seed), EXPECT_ANY);
        end
    endtask

    // memory answers each request after 1 to 4 cycles
    initial begin
        int delay;
        logic [26:0] key;
        mem_resp <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(posedge clk);
            if (arst_n && (mem_read || mem_write)) begin
                key = mem_address[31:`CACHE_OFFSET_BITS];
                if (mem_write) begin
                    mem_q[key] = mem_wdata;
                end
                delay = 1 + $unsigned($random(seed)) % 4;
                repeat (delay - 1) @(posedge clk);
                mem_resp <= 1'b1;
                mem_rdata <= mem_q.exists(key) ? mem_q[key] : memory_image(key);
                @(posedge clk);
                mem_resp <= 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        bit timed_out;
        timed_out = 0;
        cpu_read <= 1'b0;
        cpu_write <= 1'b0;
        cpu_address <= '0;
        cpu_wdata <= '0;
        cpu_wmask <= '0;
        expect_bits <= EXPECT_ANY;
        done <= 1'b0;
        build_table();

        cycles = 0;
        while (arst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            timed_out = 1;
        end

        for (int i = 0; i < addr_q.size() && !timed_out; i++) begin
            @(posedge clk);
            cpu_read <= !is_write_q[i];
            cpu_write <= is_write_q[i];
            cpu_address <= addr_q[i];
            cpu_wdata <= data_q[i];
            cpu_wmask <= mask_q[i];
            expect_bits <= expect_q[i];
            // hold the request until the response pulse
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
            end while (cpu_resp !== 1'b1 && cycles < TIMEOUT_CYCLES);
            if (cpu_resp !== 1'b1) begin
                $display("row %0d got no cpu response within %0d cycles", i, TIMEOUT_CYCLES);
                timed_out = 1;
            end
            cpu_read <= 1'b0;
            cpu_write <= 1'b0;
        end

        @(posedge clk);
        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (timed_out || error_count != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_way_meta.sv
rtl/cache_plru.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache_top.sv
tests/tb_clock_gen.sv
tests/cache_checker.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/cache_way_meta.sv
      - rtl/cache_plru.sv
      - rtl/cache_datapath.sv
      - rtl/cache_control.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/cache_checker.sv
      - tests/cache_tb.sv
